// File: prog.hex
// instruction rom image, one byte in hex per line
// comment gives the byte address and, at an instruction start, its assembly
10 // 0x00 nop
90 // 0x01 ret
00 // 0x02 halt
60 // 0x03 addq %rdx, %rbx
23 // 0x04
21 // 0x05 cmovle %rsp, %rbp
45 // 0x06
30 // 0x07 irmovq $0x0807060504030201, %rdx
f2 // 0x08
01 // 0x09
02 // 0x0a
03 // 0x0b
04 // 0x0c
05 // 0x0d
06 // 0x0e
07 // 0x0f
08 // 0x10
50 // 0x11 mrmovq 0xfedcba9876543210(%rcx), %rbx
31 // 0x12
10 // 0x13
32 // 0x14
54 // 0x15
76 // 0x16
98 // 0x17
ba // 0x18
dc // 0x19
fe // 0x1a
74 // 0x1b jne 0x40
40 // 0x1c
00 // 0x1d
00 // 0x1e
00 // 0x1f
00 // 0x20
00 // 0x21
00 // 0x22
00 // 0x23
80 // 0x24 call 0x55
55 // 0x25
00 // 0x26
00 // 0x27
00 // 0x28
00 // 0x29
00 // 0x2a
00 // 0x2b
00 // 0x2c
c5 // 0x2d invalid icode 0xc

// File: flist.f
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/byte_counter.sv
logic/fetch_ctrl.sv
logic/instr_assembler.sv
logic/fetch_unit.sv
dv/fetch_unit_checker.sv
dv/fetch_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_unit_tb \
        -f flist.f -Mdir obj_dir -o fetch_unit_sim

./obj_dir/fetch_unit_sim | tee sim.log

# a missing pass line fails the script
grep -qx '>>> PASS' sim.log

// File: dv/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb;
        timeunit 1ns;
        timeprecision 100ps;

        logic clk;
        logic reset;
        logic req;
        logic [63:0] pc;
        logic ack;
        logic [3:0] icode;
        logic [3:0] ifun;
        logic [3:0] ra;
        logic [3:0] rb;
        logic [63:0] valc;
        logic [63:0] valp;
        logic [63:0] pred_pc;
        logic instr_valid;
        logic mem_error;
        logic halt;

        // stimulus table with one slot per fetch
        string names[$];
        logic [63:0] pcs[$];
        logic [3:0] exp_icode[$];
        logic [3:0] exp_ifun[$];
        logic [3:0] exp_ra[$];
        logic [3:0] exp_rb[$];
        logic [63:0] exp_valc[$];
        logic [63:0] exp_valp[$];
        logic [63:0] exp_pred[$];
        // {instr_valid, mem_error, halt}
        logic [2:0] exp_flags[$];
        // extra cycles req stays high after ack
        int holds[$];

        int errors = 0;
        int checks = 0;
        int cycles = 0;
        int timeout_limit = 1000;

        fetch_unit fetch_unit_i (
                .clk(clk),
                .reset(reset),
                .req(req),
                .pc(pc),
                .ack(ack),
                .icode(icode),
                .ifun(ifun),
                .ra(ra),
                .rb(rb),
                .valc(valc),
                .valp(valp),
                .pred_pc(pred_pc),
                .instr_valid(instr_valid),
                .mem_error(mem_error),
                .halt(halt)
        );

        bind fetch_unit fetch_unit_checker fetch_unit_checker_i (
                .clk(clk),
                .reset(reset),
                .req(req),
                .ack(ack),
                .icode(icode),
                .ifun(ifun),
                .ra(ra),
                .rb(rb),
                .valc(valc),
                .valp(valp),
                .pred_pc(pred_pc),
                .instr_valid(instr_valid),
                .mem_error(mem_error),
                .halt(halt)
        );

        // 40 ns period
        always #20 clk = ~clk;

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= timeout_limit)
                begin
                        $display("timeout: the fetch sequence did not finish in %0d cycles",
                                 cycles);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        task automatic add_entry(input string name, input logic [63:0] addr,
                                 input logic [3:0] e_icode, input logic [3:0] e_ifun,
                                 input logic [3:0] e_ra, input logic [3:0] e_rb,
                                 input logic [63:0] e_valc, input logic [63:0] e_valp,
                                 input logic [63:0] e_pred, input logic [2:0] e_flags,
                                 input int hold);
                names.push_back(name);
                pcs.push_back(addr);
                exp_icode.push_back(e_icode);
                exp_ifun.push_back(e_ifun);
                exp_ra.push_back(e_ra);
                exp_rb.push_back(e_rb);
                exp_valc.push_back(e_valc);
                exp_valp.push_back(e_valp);
                exp_pred.push_back(e_pred);
                exp_flags.push_back(e_flags);
                holds.push_back(hold);
        endtask

        // expected fields follow prog.hex
        task automatic build_table();
                add_entry("nop", 64'd0, 4'h1, 4'h0, 4'hf, 4'hf, 64'h0, 64'd1, 64'd1, 3'b100, 0);
                // bad pc keeps the previous decode with rA rB and valC cleared at start
                add_entry("pc_128", 64'd128, 4'h1, 4'h0, 4'hf, 4'hf, 64'h0, 64'd1, 64'd1,
                          3'b110, 0);
                add_entry("ret", 64'd1, 4'h9, 4'h0, 4'hf, 4'hf, 64'h0, 64'd2, 64'd2, 3'b100, 0);
                add_entry("halt", 64'd2, 4'h0, 4'h0, 4'hf, 4'hf, 64'h0, 64'd3, 64'd3, 3'b101, 3);
                add_entry("addq", 64'd3, 4'h6, 4'h0, 4'h2, 4'h3, 64'h0, 64'd5, 64'd5, 3'b100, 2);
                add_entry("cmovle", 64'd5, 4'h2, 4'h1, 4'h4, 4'h5, 64'h0, 64'd7, 64'd7,
                          3'b100, 0);
                add_entry("irmovq", 64'd7, 4'h3, 4'h0, 4'hf, 4'h2, 64'h0807060504030201,
                          64'd17, 64'd17, 3'b100, 0);
                add_entry("mrmovq", 64'd17, 4'h5, 4'h0, 4'h3, 4'h1, 64'hfedcba9876543210,
                          64'd27, 64'd27, 3'b100, 0);
                add_entry("jne", 64'd27, 4'h7, 4'h4, 4'hf, 4'hf, 64'h40, 64'd36, 64'h40,
                          3'b100, 1);
                add_entry("call", 64'd36, 4'h8, 4'h0, 4'hf, 4'hf, 64'h55, 64'd45, 64'h55,
                          3'b100, 0);
                add_entry("invalid", 64'd45, 4'hc, 4'h5, 4'hf, 4'hf, 64'h0, 64'd46, 64'd46,
                          3'b000, 0);
                add_entry("pc_far", 64'hffff_ffff_ffff_fff0, 4'hc, 4'h5, 4'hf, 4'hf, 64'h0,
                          64'd46, 64'd46, 3'b010, 0);
        endtask

        task automatic compare(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("Error %s %s: expected %h, actual %h", test, field, expected,
                                 actual);
                end
        endtask

        task automatic check_outputs(input int i);
                compare(names[i], "icode", 64'(exp_icode[i]), 64'(icode));
                compare(names[i], "ifun", 64'(exp_ifun[i]), 64'(ifun));
                compare(names[i], "ra", 64'(exp_ra[i]), 64'(ra));
                compare(names[i], "rb", 64'(exp_rb[i]), 64'(rb));
                compare(names[i], "valc", exp_valc[i], valc);
                compare(names[i], "valp", exp_valp[i], valp);
                compare(names[i], "pred_pc", exp_pred[i], pred_pc);
                compare(names[i], "instr_valid", 64'(exp_flags[i][2]), 64'(instr_valid));
                compare(names[i], "mem_error", 64'(exp_flags[i][1]), 64'(mem_error));
                compare(names[i], "halt", 64'(exp_flags[i][0]), 64'(halt));
        endtask

        // four-phase fetch entered and left 2 ns after a rising edge
        task automatic run_entry(input int i);
                req = 1'b1;
                pc = pcs[i];
                do
                begin
                        @(posedge clk);
                        #2;
                end
                while (!ack);
                check_outputs(i);
                // requester stalls and both ack and the fields must hold
                repeat (holds[i])
                begin
                        @(posedge clk);
                        #2;
                        compare(names[i], "ack", 64'(1'b1), 64'(ack));
                        check_outputs(i);
                end
                req = 1'b0;
                while (ack)
                begin
                        @(posedge clk);
                        #2;
                end
        endtask

        initial
        begin
                int idle;
                clk = 1'b0;
                reset = 1'b1;
                req = 1'b0;
                pc = '0;
                void'($urandom(32'h8277c92d));
                build_table();
                timeout_limit = names.size() * 20 + 50;
                repeat (4) @(posedge clk);
                #2;
                reset = 1'b0;
                for (int i = 0; i < names.size(); i++)
                begin
                        // random gap between fetches
                        idle = $urandom_range(3, 0);
                        repeat (idle)
                        begin
                                @(posedge clk);
                                #2;
                        end
                        run_entry(i);
                end
                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// File: dv/fetch_unit_checker.sv
`default_nettype none

module fetch_unit_checker (
        input wire clk,
        input wire reset,
        input wire req,
        input wire ack,
        input wire [3:0] icode,
        input wire [3:0] ifun,
        input wire [3:0] ra,
        input wire [3:0] rb,
        input wire [63:0] valc,
        input wire [63:0] valp,
        input wire [63:0] pred_pc,
        input wire instr_valid,
        input wire mem_error,
        input wire halt
);
        timeunit 1ns;
        timeprecision 100ps;

        // every fetch result in one word for the hold check
        logic [210:0] results;

        assign results = {icode, ifun, ra, rb, valc, valp, pred_pc, instr_valid, mem_error, halt};

        // controller leaves reset idle
        ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
                else $error("ack is high in the cycle after reset");

        // ack only answers a request
        ack_needs_req: assert property (@(posedge clk) disable iff (reset)
                $rose(ack) |-> $past(req))
                else $error("ack rose although req was low");

        // ack holds under back-pressure until req drops
        ack_held_with_req: assert property (@(posedge clk) disable iff (reset)
                (ack && req) |=> ack)
                else $error("ack fell while req was still high");

        // fetched fields frozen for the whole ack phase
        results_stable: assert property (@(posedge clk) disable iff (reset)
                (ack && $past(ack)) |-> $stable(results))
                else $error("fetch outputs changed while ack was high");

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none

module fetch_unit (
        input wire clk,
        input wire reset,
        input wire req,
        input wire fetch_pkg::addr_t pc,
        output logic ack,
        output fetch_pkg::icode_t icode,
        output fetch_pkg::icode_t ifun,
        output fetch_pkg::icode_t ra,
        output fetch_pkg::icode_t rb,
        output fetch_pkg::addr_t valc,
        output fetch_pkg::addr_t valp,
        output fetch_pkg::addr_t pred_pc,
        output logic instr_valid,
        output logic mem_error,
        output logic halt
);
        import fetch_pkg::*;

        // fetch address latched by the controller
        addr_t base_pc;
        logic start;
        logic step;
        logic byte_valid;
        // instruction length and byte position
        logic [byte_idx_width-1:0] limit;
        logic [byte_idx_width-1:0] index;
        logic last;
        // rom side
        logic [7:0] rd_data;
        logic out_of_range;

        // handshake and read sequencing
        fetch_ctrl fetch_ctrl_i (
                .clk(clk),
                .reset(reset),
                .req(req),
                .pc(pc),
                .out_of_range(out_of_range),
                .icode(icode),
                .last(last),
                .ack(ack),
                .base_pc(base_pc),
                .limit(limit),
                .start(start),
                .step(step),
                .byte_valid(byte_valid),
                .mem_error(mem_error)
        );

        byte_counter byte_counter_i (
                .clk(clk),
                .reset(reset),
                .start(start),
                .step(step),
                .limit(limit),
                .index(index),
                .last(last)
        );

        instr_mem instr_mem_i (
                .clk(clk),
                .base(base_pc),
                .index(index),
                .rd_data(rd_data),
                .out_of_range(out_of_range)
        );

        // decoded fields, valp and the predicted pc
        instr_assembler instr_assembler_i (
                .clk(clk),
                .reset(reset),
                .start(start),
                .byte_valid(byte_valid),
                .index(index),
                .rd_data(rd_data),
                .base_pc(base_pc),
                .icode(icode),
                .ifun(ifun),
                .ra(ra),
                .rb(rb),
                .valc(valc),
                .valp(valp),
                .pred_pc(pred_pc),
                .instr_valid(instr_valid),
                .halt(halt)
        );

endmodule

`default_nettype wire

// File: logic/instr_assembler.sv
`default_nettype none

module instr_assembler (
        input wire clk,
        input wire reset,
        input wire start,
        input wire byte_valid,
        input wire [fetch_pkg::byte_idx_width-1:0] index,
        input wire [7:0] rd_data,
        input wire fetch_pkg::addr_t base_pc,
        output fetch_pkg::icode_t icode,
        output fetch_pkg::icode_t ifun,
        output fetch_pkg::icode_t ra,
        output fetch_pkg::icode_t rb,
        output fetch_pkg::addr_t valc,
        output fetch_pkg::addr_t valp,
        output fetch_pkg::addr_t pred_pc,
        output logic instr_valid,
        output logic halt
);
        import fetch_pkg::*;

        // position of the byte on rd_data which lags the counter like the rom
        logic [byte_idx_width-1:0] idx_q;
        // where valc begins within the instruction
        logic [byte_idx_width-1:0] valc_first;
        // byte lane of valc for the current byte
        logic [byte_idx_width-1:0] valc_pos;
        logic valc_byte;
        icode_t byte_icode;

        assign byte_icode = rd_data[7:4];
        assign valc_first = has_regids(icode) ? byte_idx_width'(2) : byte_idx_width'(1);
        assign valc_pos = idx_q - valc_first;
        assign valc_byte = has_valc(icode) && (idx_q >= valc_first);

        // jumps and calls predict their target while the rest fall through
        assign pred_pc = ((icode == icode_jxx) || (icode == icode_call)) ? valc : valp;

        always_ff @(posedge clk)
        begin
                idx_q <= index;
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        icode <= '0;
                        ifun <= '0;
                        ra <= '0;
                        rb <= '0;
                        valc <= '0;
                        valp <= '0;
                        instr_valid <= 1'b0;
                        halt <= 1'b0;
                end
                // fields not present in the instruction read as rnone and zero
                else if (start)
                begin
                        ra <= 4'hf;
                        rb <= 4'hf;
                        valc <= '0;
                end
                else if (byte_valid)
                begin
                        // byte 0 decides the length and validity
                        if (idx_q == '0)
                        begin
                                icode <= byte_icode;
                                ifun <= rd_data[3:0];
                                valp <= base_pc + addr_t'(instr_length(byte_icode));
                                instr_valid <= (byte_icode <= icode_pop);
                                halt <= (byte_icode == icode_halt);
                        end
                        // register specifier byte with ra in the high nibble
                        if ((idx_q == byte_idx_width'(1)) && has_regids(icode))
                        begin
                                ra <= rd_data[7:4];
                                rb <= rd_data[3:0];
                        end
                        // little-endian constant with the lowest byte first
                        if (valc_byte)
                                valc[{valc_pos[2:0], 3'b000} +: 8] <= rd_data;
                end
        end

endmodule

`default_nettype wire

// File: logic/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
        input wire clk,
        input wire reset,
        input wire req,
        input wire fetch_pkg::addr_t pc,
        input wire out_of_range,
        input wire fetch_pkg::icode_t icode,
        input wire last,
        output logic ack,
        output fetch_pkg::addr_t base_pc,
        output logic [fetch_pkg::byte_idx_width-1:0] limit,
        output logic start,
        output logic step,
        output logic byte_valid,
        output logic mem_error
);
        import fetch_pkg::*;

        typedef enum logic [2:0] {idle, read, wait_first, read_rest, done} state_t;

        state_t state;
        state_t state_next;
        // counter moved last cycle so the rom reads a new byte now
        logic step_q;
        // rom is addressing a wanted byte this cycle
        logic reading;
        logic issue;
        logic range_fault;

        // ack is a pure state decode since outputs are already final in done
        assign ack = (state == done);
        assign start = (state == idle) && req;
        // icode is valid from read_rest on
        assign limit = instr_length(icode);

        assign reading = (state == read) || ((state == read_rest) && step_q);
        assign issue = reading && !out_of_range;
        assign range_fault = reading && out_of_range;
        // keep stepping until the counter sits on the final byte
        assign step = (state == read_rest) && !last && !range_fault;

        always_comb
        begin
                state_next = state;
                case (state)
                        idle:
                                if (req)
                                        state_next = read;
                        // byte 0 is read here and a bad pc skips straight to done
                        read:
                                if (range_fault)
                                        state_next = done;
                                else
                                        state_next = wait_first;
                        // byte 0 lands in the assembler
                        wait_first:
                                state_next = read_rest;
                        // leave once the final read has been captured
                        read_rest:
                                if (range_fault || (last && !step_q))
                                        state_next = done;
                        // hold ack until the requester lets go
                        done:
                                if (!req)
                                        state_next = idle;
                        default:
                                state_next = idle;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= idle;
                        step_q <= 1'b0;
                        byte_valid <= 1'b0;
                        mem_error <= 1'b0;
                end
                else
                begin
                        state <= state_next;
                        step_q <= step;
                        // rom data follows the read by one cycle
                        byte_valid <= issue;
                        if (start)
                                mem_error <= 1'b0;
                        else if (range_fault)
                                mem_error <= 1'b1;
                end
        end

        // pc captured once per fetch
        always_ff @(posedge clk)
        begin
                if (start)
                        base_pc <= pc;
        end

endmodule

`default_nettype wire

// File: logic/byte_counter.sv
`default_nettype none

module byte_counter (
        input wire clk,
        input wire reset,
        input wire start,
        input wire step,
        input wire [fetch_pkg::byte_idx_width-1:0] limit,
        output logic [fetch_pkg::byte_idx_width-1:0] index,
        output logic last
);
        import fetch_pkg::*;

        // index of the following byte
        logic [byte_idx_width-1:0] index_inc;

        assign index_inc = index + byte_idx_width'(1);
        // current index is the final byte of the instruction
        assign last = (index_inc == limit);

        always_ff @(posedge clk)
        begin
                if (reset)
                        index <= '0;
                else if (start)
                        index <= '0;
                // one byte per step with no extra latency
                else if (step)
                        index <= index_inc;
        end

endmodule

`default_nettype wire

// File: logic/instr_mem.sv
`default_nettype none

module instr_mem (
        input wire clk,
        input wire fetch_pkg::addr_t base,
        input wire [fetch_pkg::byte_idx_width-1:0] index,
        output logic [7:0] rd_data,
        output logic out_of_range
);
        import fetch_pkg::*;

        // one byte per word with the program image loaded at elaboration
        logic [7:0] mem [mem_bytes];
        // byte address currently presented to the rom
        addr_t addr;

        initial
        begin
                $readmemh("prog.hex", mem);
        end

        assign addr = base + addr_t'(index);
        // anything at or past the end of the rom is a memory error
        assign out_of_range = (addr >= addr_t'(mem_bytes));

        // one cycle read latency
        // addresses outside the array read as zero
        always_ff @(posedge clk)
        begin
                if (out_of_range)
                        rd_data <= 8'h00;
                else
                        rd_data <= mem[addr[mem_addr_width-1:0]];
        end

endmodule

`default_nettype wire

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

        // pc, valc, valp and pred_pc are full 64-bit words
        localparam int unsigned addr_width = 64;
        // instruction rom size in bytes
        localparam int unsigned mem_bytes = 128;
        localparam int unsigned mem_addr_width = $clog2(mem_bytes);
        // byte position inside one instruction
        localparam int unsigned byte_idx_width = 4;
        // the longest instruction has 10 bytes
        localparam int unsigned max_instr_bytes = 10;

        typedef logic [3:0] icode_t;
        typedef logic [addr_width-1:0] addr_t;

        // y86-64 instruction codes from the upper nibble of byte 0
        localparam icode_t icode_halt = 4'h0;
        localparam icode_t icode_nop = 4'h1;
        localparam icode_t icode_cmov = 4'h2;
        localparam icode_t icode_irmov = 4'h3;
        localparam icode_t icode_rmmov = 4'h4;
        localparam icode_t icode_mrmov = 4'h5;
        localparam icode_t icode_op = 4'h6;
        localparam icode_t icode_jxx = 4'h7;
        localparam icode_t icode_call = 4'h8;
        localparam icode_t icode_ret = 4'h9;
        localparam icode_t icode_push = 4'ha;
        localparam icode_t icode_pop = 4'hb;

        // total bytes of an instruction where an invalid code counts as one byte
        function automatic logic [byte_idx_width-1:0] instr_length(input icode_t icode);
                case (icode)
                        icode_cmov, icode_op, icode_push, icode_pop:
                                return byte_idx_width'(2);
                        icode_jxx, icode_call:
                                return byte_idx_width'(max_instr_bytes - 1);
                        icode_irmov, icode_rmmov, icode_mrmov:
                                return byte_idx_width'(max_instr_bytes);
                        default:
                                return byte_idx_width'(1);
                endcase
        endfunction

        // byte 1 carries ra and rb
        function automatic logic has_regids(input icode_t icode);
                return icode inside {icode_cmov, icode_irmov, icode_rmmov, icode_mrmov,
                                     icode_op, icode_push, icode_pop};
        endfunction

        // eight little-endian bytes of valc follow
        function automatic logic has_valc(input icode_t icode);
                return icode inside {icode_irmov, icode_rmmov, icode_mrmov,
                                     icode_jxx, icode_call};
        endfunction

endpackage

`default_nettype wire
